//--- testbench/clint_tb.sv
// CLINT directed testbench
`timescale 1ns/10ps

module clint_tb;

  localparam int NUM_TESTS = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 1000;
  localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_0200_0100;

  logic clk = 1'b0;
  logic rst;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  axi_pkg::axi_addr_t aw_addr_i, ar_addr_i;
  axi_pkg::axi_id_t aw_id_i, b_id_o, ar_id_i, r_id_o;
  axi_pkg::axi_data_t w_data_i, r_data_o;
  axi_pkg::axi_strb_t w_strb_i;
  axi_pkg::axi_resp_t b_resp_o, r_resp_o;
  clint_pkg::irq_bus_t irq_o;

  int errors = 0;
  longint unsigned cycle_cnt = 0;
  // register contents as the testbench expects them
  logic [63:0] model_cmp;
  logic [31:0] model_msip;

  clint_top clint_top_inst (.*);

  always #5 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic show_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  function automatic logic [63:0] apply_strobes(input logic [63:0] old_val,
                                                input logic [63:0] new_val,
                                                input logic [7:0] strb);
    logic [63:0] res;
    res = old_val;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  task automatic axi_read(input logic [63:0] addr, input logic [3:0] id, input int stall,
                          output logic [63:0] data, output logic [1:0] resp,
                          output logic [3:0] rid, output longint unsigned hs_cycle);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    do @(posedge clk); while (!ar_ready_o);
    hs_cycle = cycle_cnt;
    ar_valid_i <= 1'b0;
    do @(posedge clk); while (!r_valid_o);
    data = r_data_o;
    resp = r_resp_o;
    rid  = r_id_o;
    if (r_last_o !== 1'b1) show_mismatch("r_last_o", 1, r_last_o);
    // payload must hold while ready is low
    repeat (stall) begin
      @(posedge clk);
      if (r_valid_o !== 1'b1) show_mismatch("r_valid_o", 1, r_valid_o);
      if (r_data_o !== data) show_mismatch("r_data_o", data, r_data_o);
      if (r_resp_o !== resp) show_mismatch("r_resp_o", resp, r_resp_o);
      if (r_id_o !== rid) show_mismatch("r_id_o", rid, r_id_o);
    end
    r_ready_i <= 1'b1;
    @(posedge clk);
    r_ready_i <= 1'b0;
  endtask

  task automatic axi_write(input logic [63:0] addr, input logic [3:0] id,
                           input logic [63:0] data0, input logic [7:0] strb0,
                           input logic [63:0] data1, input logic [7:0] strb1,
                           input int beats, input int stall,
                           output logic [1:0] resp, output logic [3:0] bid);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    do @(posedge clk); while (!aw_ready_o);
    aw_valid_i <= 1'b0;
    for (int b = 0; b < beats; b++) begin
      w_valid_i <= 1'b1;
      w_data_i  <= (b == 0) ? data0 : data1;
      w_strb_i  <= (b == 0) ? strb0 : strb1;
      w_last_i  <= (b == beats - 1);
      do @(posedge clk); while (!w_ready_o);
    end
    w_valid_i <= 1'b0;
    w_last_i  <= 1'b0;
    do @(posedge clk); while (!b_valid_o);
    resp = b_resp_o;
    bid  = b_id_o;
    repeat (stall) begin
      @(posedge clk);
      if (b_valid_o !== 1'b1) show_mismatch("b_valid_o", 1, b_valid_o);
      if (b_resp_o !== resp) show_mismatch("b_resp_o", resp, b_resp_o);
      if (b_id_o !== bid) show_mismatch("b_id_o", bid, b_id_o);
    end
    b_ready_i <= 1'b1;
    @(posedge clk);
    b_ready_i <= 1'b0;
  endtask

  // single beat write with OKAY and id echo checked
  task automatic write_reg(input logic [63:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int stall);
    logic [1:0] resp;
    logic [3:0] id, bid;
    id = 4'($urandom);
    axi_write(addr, id, data, strb, 64'h0, 8'h0, 1, stall, resp, bid);
    if (resp !== axi_pkg::RESP_OKAY) show_mismatch("b_resp_o", axi_pkg::RESP_OKAY, resp);
    if (bid !== id) show_mismatch("b_id_o", id, bid);
  endtask

  task automatic read_check(input logic [63:0] addr, input logic [63:0] exp, input int stall);
    logic [63:0] data;
    logic [1:0] resp;
    logic [3:0] id, rid;
    longint unsigned hs;
    id = 4'($urandom);
    axi_read(addr, id, stall, data, resp, rid, hs);
    if (data !== exp) show_mismatch("r_data_o", exp, data);
    if (resp !== axi_pkg::RESP_OKAY) show_mismatch("r_resp_o", axi_pkg::RESP_OKAY, resp);
    if (rid !== id) show_mismatch("r_id_o", id, rid);
  endtask

  task automatic test_reset();
    if (irq_o !== 2'b00) show_mismatch("irq_o", 0, irq_o);
    if (r_valid_o !== 1'b0) show_mismatch("r_valid_o", 0, r_valid_o);
    if (b_valid_o !== 1'b0) show_mismatch("b_valid_o", 0, b_valid_o);
    if (ar_ready_o !== 1'b1) show_mismatch("ar_ready_o", 1, ar_ready_o);
    if (aw_ready_o !== 1'b1) show_mismatch("aw_ready_o", 1, aw_ready_o);
    if (w_ready_o !== 1'b0) show_mismatch("w_ready_o", 0, w_ready_o);
    read_check(clint_pkg::MTIMECMP_ADDR, clint_pkg::MTIMECMP_RST, 0);
    read_check(clint_pkg::MSIP_ADDR, 64'h0, 0);
  endtask

  task automatic test_strobed_writes();
    logic [63:0] data, data1;
    logic [7:0] strb;
    logic [1:0] resp;
    logic [3:0] id, bid;
    repeat (4) begin
      data = {$urandom, $urandom};
      strb = 8'($urandom);
      write_reg(clint_pkg::MTIMECMP_ADDR, data, strb, 0);
      model_cmp = apply_strobes(model_cmp, data, strb);
      read_check(clint_pkg::MTIMECMP_ADDR, model_cmp, 0);
    end
    // msip takes only the low word and reads back sign extended
    data = {$urandom, 1'b1, 31'($urandom)};
    write_reg(clint_pkg::MSIP_ADDR, data, 8'hff, 0);
    model_msip = data[31:0];
    read_check(clint_pkg::MSIP_ADDR, {{32{model_msip[31]}}, model_msip}, 0);
    data = {$urandom, $urandom};
    strb = 8'($urandom);
    write_reg(clint_pkg::MSIP_ADDR, data, strb, 0);
    model_msip = 32'(apply_strobes({32'h0, model_msip}, data, {4'h0, strb[3:0]}));
    read_check(clint_pkg::MSIP_ADDR, {{32{model_msip[31]}}, model_msip}, 0);
    // two beat burst to one address
    data  = {$urandom, $urandom};
    data1 = {$urandom, $urandom};
    strb  = 8'($urandom);
    id    = 4'($urandom);
    axi_write(clint_pkg::MTIMECMP_ADDR, id, data, 8'hff, data1, strb, 2, 0, resp, bid);
    if (resp !== axi_pkg::RESP_OKAY) show_mismatch("b_resp_o", axi_pkg::RESP_OKAY, resp);
    if (bid !== id) show_mismatch("b_id_o", id, bid);
    model_cmp = apply_strobes(data, data1, strb);
    read_check(clint_pkg::MTIMECMP_ADDR, model_cmp, 0);
  endtask

  task automatic test_mtime_count();
    logic [63:0] start, v1, v2;
    logic [1:0] resp;
    logic [3:0] rid;
    longint unsigned c1, c2;
    start = {32'h0, $urandom};
    write_reg(clint_pkg::MTIME_ADDR, start, 8'hff, 0);
    axi_read(clint_pkg::MTIME_ADDR, 4'h3, 0, v1, resp, rid, c1);
    axi_read(clint_pkg::MTIME_ADDR, 4'h5, 0, v2, resp, rid, c2);
    if (v1 < start) $display("FAILED at %0t ns: mtime %h is below written %h", $time, v1, start);
    if (v1 < start) errors++;
    if (v2 - v1 !== 64'(c2 - c1)) show_mismatch("mtime delta", 64'(c2 - c1), v2 - v1);
  endtask

  task automatic test_interrupts();
    write_reg(clint_pkg::MSIP_ADDR, 64'h1, 8'h0f, 0);
    if (irq_o[clint_pkg::IRQ_SOFT] !== 1'b1) show_mismatch("irq_o[soft]", 1, irq_o[0]);
    write_reg(clint_pkg::MSIP_ADDR, 64'h0, 8'h0f, 0);
    if (irq_o[clint_pkg::IRQ_SOFT] !== 1'b0) show_mismatch("irq_o[soft]", 0, irq_o[0]);
    model_msip = 32'h0;
    write_reg(clint_pkg::MTIMECMP_ADDR, 64'd50, 8'hff, 0);
    write_reg(clint_pkg::MTIME_ADDR, 64'd0, 8'hff, 0);
    if (irq_o[clint_pkg::IRQ_TIMER] !== 1'b0) show_mismatch("irq_o[timer]", 0, irq_o[1]);
    repeat (60) @(posedge clk);
    if (irq_o[clint_pkg::IRQ_TIMER] !== 1'b1) show_mismatch("irq_o[timer]", 1, irq_o[1]);
    write_reg(clint_pkg::MTIMECMP_ADDR, '1, 8'hff, 0);
    model_cmp = '1;
    if (irq_o[clint_pkg::IRQ_TIMER] !== 1'b0) show_mismatch("irq_o[timer]", 0, irq_o[1]);
  endtask

  task automatic test_unmapped_backpressure();
    logic [63:0] data;
    logic [1:0] resp;
    logic [3:0] rid, bid;
    longint unsigned hs;
    axi_read(UNMAPPED_ADDR, 4'h9, 0, data, resp, rid, hs);
    if (data !== 64'h0) show_mismatch("r_data_o", 0, data);
    if (resp !== axi_pkg::RESP_DECERR) show_mismatch("r_resp_o", axi_pkg::RESP_DECERR, resp);
    axi_write(UNMAPPED_ADDR, 4'ha, {$urandom, $urandom}, 8'hff, 64'h0, 8'h0, 1, 0, resp, bid);
    if (resp !== axi_pkg::RESP_DECERR) show_mismatch("b_resp_o", axi_pkg::RESP_DECERR, resp);
    // stalled responses, stability checked inside the drivers
    read_check(clint_pkg::MTIMECMP_ADDR, model_cmp, 1 + $urandom % 8);
    write_reg(clint_pkg::MSIP_ADDR, 64'h0, 8'h0f, 1 + $urandom % 8);
    read_check(clint_pkg::MSIP_ADDR, 64'h0, 1 + $urandom % 8);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout: run did not finish within %0d cycles, errors so far %0d",
             WATCHDOG_CYCLES, errors);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h8ab2e5d2));
    rst <= 1'b1;
    aw_valid_i <= 1'b0;
    aw_addr_i  <= '0;
    aw_id_i    <= '0;
    w_valid_i  <= 1'b0;
    w_data_i   <= '0;
    w_strb_i   <= '0;
    w_last_i   <= 1'b0;
    b_ready_i  <= 1'b0;
    ar_valid_i <= 1'b0;
    ar_addr_i  <= '0;
    ar_id_i    <= '0;
    r_ready_i  <= 1'b0;
    model_cmp  = clint_pkg::MTIMECMP_RST;
    model_msip = 32'h0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_reset();
    test_strobed_writes();
    test_mtime_count();
    test_interrupts();
    test_unmapped_backpressure();
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/axi_pkg.sv
verilog/clint_pkg.sv
verilog/clint_axi_read.sv
verilog/clint_axi_write.sv
verilog/clint_regs.sv
verilog/clint_top.sv
testbench/clint_tb.sv

//--- verilog/axi_pkg.sv
// AXI slave port definitions
package axi_pkg;

  // bus widths
  localparam int AXI_ADDR_W = 64;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ID_W   = 4;

  typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;
  typedef logic [AXI_ID_W-1:0]     axi_id_t;
  typedef logic [1:0]              axi_resp_t;

  // response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

//--- verilog/clint_axi_read.sv
// AXI read channel engine
`timescale 1ns/10ps

module clint_axi_read (
  input  logic                clk,
  input  logic                rst,

  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_pkg::axi_addr_t  ar_addr_i,
  input  axi_pkg::axi_id_t    ar_id_i,

  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_pkg::axi_data_t  r_data_o,
  output axi_pkg::axi_resp_t  r_resp_o,
  output axi_pkg::axi_id_t    r_id_o,
  output logic                r_last_o,

  output axi_pkg::axi_addr_t  rd_addr_o,
  input  axi_pkg::axi_data_t  rd_data_i,
  input  logic                rd_hit_i
);

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

  rd_state_t state_q;

  axi_pkg::axi_data_t data_q;
  axi_pkg::axi_resp_t resp_q;
  axi_pkg::axi_id_t   id_q;

  logic ar_hs;
  logic r_hs;

  assign ar_ready_o = (state_q == RD_IDLE);
  assign r_valid_o  = (state_q == RD_RESP);

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;

  // register block decodes the request address directly
  assign rd_addr_o = ar_addr_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RD_IDLE;
    end else begin
      case (state_q)
        RD_IDLE: if (ar_hs) state_q <= RD_RESP;
        RD_RESP: if (r_hs) state_q <= RD_IDLE;
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // snapshot on the AR edge
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      data_q <= rd_data_i;
      resp_q <= rd_hit_i ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
      id_q   <= ar_id_i;
    end
  end

  assign r_data_o = data_q;
  assign r_resp_o = resp_q;
  assign r_id_o   = id_q;
  // single beat, so every beat is the last
  assign r_last_o = r_valid_o;

  r_hold_a: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

//--- verilog/clint_axi_write.sv
// AXI write channel engine
`timescale 1ns/10ps

module clint_axi_write (
  input  logic                clk,
  input  logic                rst,

  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_pkg::axi_addr_t  aw_addr_i,
  input  axi_pkg::axi_id_t    aw_id_i,

  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_pkg::axi_data_t  w_data_i,
  input  axi_pkg::axi_strb_t  w_strb_i,
  input  logic                w_last_i,

  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_pkg::axi_resp_t  b_resp_o,
  output axi_pkg::axi_id_t    b_id_o,

  output logic                wr_en_o,
  output axi_pkg::axi_addr_t  wr_addr_o,
  output axi_pkg::axi_data_t  wr_data_o,
  output axi_pkg::axi_strb_t  wr_strb_o,
  input  logic                wr_hit_i
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  wr_state_t state_q;

  axi_pkg::axi_addr_t addr_q;
  axi_pkg::axi_id_t   id_q;
  axi_pkg::axi_resp_t resp_q;
  logic               hit_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic burst_hit;

  assign aw_ready_o = (state_q == WR_IDLE);
  assign w_ready_o  = (state_q == WR_DATA);
  assign b_valid_o  = (state_q == WR_RESP);

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= WR_IDLE;
    end else begin
      case (state_q)
        WR_IDLE: if (aw_hs) state_q <= WR_DATA;
        WR_DATA: if (w_hs && w_last_i) state_q <= WR_RESP;
        WR_RESP: if (b_hs) state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr_q <= aw_addr_i;
      id_q   <= aw_id_i;
    end
  end

  // every beat lands on the captured address
  assign wr_en_o   = w_hs;
  assign wr_addr_o = addr_q;
  assign wr_data_o = w_data_i;
  assign wr_strb_o = w_strb_i;

  // okay if any beat of the burst decoded
  assign burst_hit = hit_q || wr_hit_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_q <= 1'b0;
    end else if (aw_hs) begin
      hit_q <= 1'b0;
    end else if (w_hs) begin
      hit_q <= burst_hit;
    end
  end

  // response held until B is taken
  always_ff @(posedge clk) begin
    if (w_hs && w_last_i) begin
      resp_q <= burst_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
    end
  end

  assign b_resp_o = resp_q;
  assign b_id_o   = id_q;

  b_hold_a: assert property (@(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o) && $stable(b_id_o));

endmodule

//--- verilog/clint_pkg.sv
// CLINT register map and types
package clint_pkg;

  // register addresses
  localparam axi_pkg::axi_addr_t MSIP_ADDR     = 64'h0000_0000_0200_0000;
  localparam axi_pkg::axi_addr_t MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
  localparam axi_pkg::axi_addr_t MTIME_ADDR    = 64'h0000_0000_0200_BFF8;

  // register contents
  typedef logic [31:0] msip_t;
  typedef logic [63:0] clint_time_t;

  // timer compare comes out of reset well in the future
  localparam clint_time_t MTIMECMP_RST = 64'h0000_0000_0010_0000;

  // interrupt lines to the hart
  localparam int IRQ_SOFT  = 0;
  localparam int IRQ_TIMER = 1;

  typedef logic [1:0] irq_bus_t;

endpackage

//--- verilog/clint_regs.sv
// CLINT register block
`timescale 1ns/10ps

module clint_regs (
  input  logic                clk,
  input  logic                rst,

  input  axi_pkg::axi_addr_t  rd_addr_i,
  output axi_pkg::axi_data_t  rd_data_o,
  output logic                rd_hit_o,

  input  logic                wr_en_i,
  input  axi_pkg::axi_addr_t  wr_addr_i,
  input  axi_pkg::axi_data_t  wr_data_i,
  input  axi_pkg::axi_strb_t  wr_strb_i,
  output logic                wr_hit_o,

  output clint_pkg::irq_bus_t irq_o
);

  clint_pkg::msip_t       msip_q;
  clint_pkg::clint_time_t mtimecmp_q;
  clint_pkg::clint_time_t mtime_q;

  logic rd_msip;
  logic rd_mtimecmp;
  logic rd_mtime;

  logic hit_msip;
  logic hit_mtimecmp;
  logic hit_mtime;

  logic msip_we;
  logic mtimecmp_we;
  logic mtime_we;

  axi_pkg::axi_data_t wr_mask;

  // keep old bytes where the strobe is clear
  function automatic axi_pkg::axi_data_t merge(input axi_pkg::axi_data_t old_val,
                                               input axi_pkg::axi_data_t new_val,
                                               input axi_pkg::axi_data_t mask);
    merge = (old_val & ~mask) | (new_val & mask);
  endfunction

  // read decode
  assign rd_msip     = (rd_addr_i == clint_pkg::MSIP_ADDR);
  assign rd_mtimecmp = (rd_addr_i == clint_pkg::MTIMECMP_ADDR);
  assign rd_mtime    = (rd_addr_i == clint_pkg::MTIME_ADDR);
  assign rd_hit_o    = rd_msip || rd_mtimecmp || rd_mtime;

  always_comb begin
    rd_data_o = '0;
    if (rd_msip) begin
      // msip is sign extended to the bus width
      rd_data_o = {{32{msip_q[31]}}, msip_q};
    end else if (rd_mtimecmp) begin
      rd_data_o = mtimecmp_q;
    end else if (rd_mtime) begin
      rd_data_o = mtime_q;
    end
  end

  // write decode
  assign hit_msip     = (wr_addr_i == clint_pkg::MSIP_ADDR);
  assign hit_mtimecmp = (wr_addr_i == clint_pkg::MTIMECMP_ADDR);
  assign hit_mtime    = (wr_addr_i == clint_pkg::MTIME_ADDR);
  assign wr_hit_o     = hit_msip || hit_mtimecmp || hit_mtime;

  assign msip_we     = wr_en_i && hit_msip;
  assign mtimecmp_we = wr_en_i && hit_mtimecmp;
  assign mtime_we    = wr_en_i && hit_mtime;

  // byte strobes to bit mask
  always_comb begin
    for (int i = 0; i < axi_pkg::AXI_DATA_W / 8; i++) begin
      wr_mask[8*i +: 8] = {8{wr_strb_i[i]}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= '0;
    end else if (msip_we) begin
      msip_q <= (msip_q & ~wr_mask[31:0]) | (wr_data_i[31:0] & wr_mask[31:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= clint_pkg::MTIMECMP_RST;
    end else if (mtimecmp_we) begin
      mtimecmp_q <= merge(mtimecmp_q, wr_data_i, wr_mask);
    end
  end

  // free running, a write replaces the increment
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (mtime_we) begin
      mtime_q <= merge(mtime_q, wr_data_i, wr_mask);
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_comb begin
    irq_o = '0;
    irq_o[clint_pkg::IRQ_SOFT]  = msip_q[0];
    irq_o[clint_pkg::IRQ_TIMER] = (mtime_q >= mtimecmp_q);
  end

  wr_sel_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0({msip_we, mtimecmp_we, mtime_we}));

endmodule

//--- verilog/clint_top.sv
// CLINT with AXI4 slave port
`timescale 1ns/10ps

module clint_top (
  input  logic                clk,
  input  logic                rst,

  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_pkg::axi_addr_t  aw_addr_i,
  input  axi_pkg::axi_id_t    aw_id_i,

  input  logic                w_valid_i,
  output logic                w_ready_o,
  input  axi_pkg::axi_data_t  w_data_i,
  input  axi_pkg::axi_strb_t  w_strb_i,
  input  logic                w_last_i,

  output logic                b_valid_o,
  input  logic                b_ready_i,
  output axi_pkg::axi_resp_t  b_resp_o,
  output axi_pkg::axi_id_t    b_id_o,

  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  axi_pkg::axi_addr_t  ar_addr_i,
  input  axi_pkg::axi_id_t    ar_id_i,

  output logic                r_valid_o,
  input  logic                r_ready_i,
  output axi_pkg::axi_data_t  r_data_o,
  output axi_pkg::axi_resp_t  r_resp_o,
  output axi_pkg::axi_id_t    r_id_o,
  output logic                r_last_o,

  output clint_pkg::irq_bus_t irq_o
);

  // read side
  axi_pkg::axi_addr_t rd_addr;
  axi_pkg::axi_data_t rd_data;
  logic               rd_hit;

  // write side
  logic               wr_en;
  axi_pkg::axi_addr_t wr_addr;
  axi_pkg::axi_data_t wr_data;
  axi_pkg::axi_strb_t wr_strb;
  logic               wr_hit;

  clint_axi_read clint_axi_read_inst (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_id_o     (r_id_o),
    .r_last_o   (r_last_o),
    .rd_addr_o  (rd_addr),
    .rd_data_i  (rd_data),
    .rd_hit_i   (rd_hit)
  );

  clint_axi_write clint_axi_write_inst (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_last_i   (w_last_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .wr_en_o    (wr_en),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_strb_o  (wr_strb),
    .wr_hit_i   (wr_hit)
  );

  clint_regs clint_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .rd_hit_o   (rd_hit),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_strb_i  (wr_strb),
    .wr_hit_o   (wr_hit),
    .irq_o      (irq_o)
  );

endmodule
